// File: msi_pkg.sv
package msi_pkg;

  // ---------------------------------------------------------------------
  // interrupt and destination sizes
  // ---------------------------------------------------------------------
  localparam int NUM_IRQ    = 4;
  localparam int IRQ_IDX_W  = 2;
  localparam int NUM_DEST   = 2;
  localparam int DEST_IDX_W = 1;

  // ---------------------------------------------------------------------
  // AXI4-Lite write channel sizes
  // ---------------------------------------------------------------------
  localparam int ADDR_W = 40;
  localparam int DATA_W = 64;
  localparam int STRB_W = 8;
  localparam int RESP_W = 2;

  // bresp encoding, only OKAY is checked
  localparam logic [RESP_W-1:0] RESP_OKAY = 2'b00;

  // ---------------------------------------------------------------------
  // message fields
  // ---------------------------------------------------------------------
  localparam int DEVICE_ID_W = 16;
  localparam int EVENT_ID_W  = 16;
  localparam int THROTTLE_W  = 16;

  // device id lands on a 4-byte boundary in the address
  localparam int ADDR_PAD_W = ADDR_W - DEVICE_ID_W - 2;

  // event id sits zero-extended in one 32-bit lane
  localparam int LANE_W      = 32;
  localparam int NUM_LANES   = DATA_W / LANE_W;
  localparam int EVENT_PAD_W = LANE_W - EVENT_ID_W;

  localparam logic [STRB_W-1:0] STRB_LO_LANE = 8'h0F;
  localparam logic [STRB_W-1:0] STRB_HI_LANE = 8'hF0;

  // send fsm state codes
  localparam int STATE_W = 2;
  localparam logic [STATE_W-1:0] ST_IDLE  = 2'd0;
  localparam logic [STATE_W-1:0] ST_WAIT  = 2'd1;
  localparam logic [STATE_W-1:0] ST_ISSUE = 2'd2;

  // write data word, seen whole on the bus or as two lanes by the builder
  typedef union packed {
    logic [DATA_W-1:0]                 word;
    logic [NUM_LANES-1:0][LANE_W-1:0]  lane;
  } msi_wdata_u;

endpackage

// File: msi_irq_tracker.sv
`timescale 1ns/10ps

module msi_irq_tracker (
  input  logic                        clk,
  input  logic                        reset,
  input  logic [msi_pkg::NUM_IRQ-1:0] irq,
  input  logic [msi_pkg::NUM_IRQ-1:0] msi_enable,
  input  logic [msi_pkg::IRQ_IDX_W-1:0] grant_idx,
  input  logic                        send_done,
  output logic [msi_pkg::NUM_IRQ-1:0] pending
);

  import msi_pkg::*;

  // previous irq sample for edge detection
  logic [NUM_IRQ-1:0] irq_d;
  // lines that went from low to high this cycle
  logic [NUM_IRQ-1:0] irq_rise;
  // one-hot clear for the line whose message just went out
  logic [NUM_IRQ-1:0] clr_mask;
  logic [NUM_IRQ-1:0] pending_next;

  // ---------------------------------------------------------------------
  // edge detect
  // ---------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      irq_d <= '0;
    end else begin
      irq_d <= irq;
    end
  end

  // a line held high only fires once, a new pulse fires again
  assign irq_rise = irq & ~irq_d;

  // ---------------------------------------------------------------------
  // pending bits
  // ---------------------------------------------------------------------
  always_comb begin
    clr_mask = '0;
    // grant_idx is held by the arbiter while the message is in flight
    if (send_done) begin
      clr_mask[grant_idx] = 1'b1;
    end
  end

  // set on edge, drop on accept, and drop whenever the line is disabled
  assign pending_next = msi_enable & (pending | irq_rise) & ~clr_mask;

  always_ff @(posedge clk) begin
    if (reset) begin
      pending <= '0;
    end else begin
      pending <= pending_next;
    end
  end

endmodule

// File: msi_rr_arbiter.sv
`timescale 1ns/10ps

module msi_rr_arbiter (
  input  logic                          clk,
  input  logic                          reset,
  input  logic [msi_pkg::NUM_IRQ-1:0]   pending,
  input  logic                          send_done,
  input  logic                          grant_lock,
  output logic                          grant_valid,
  output logic [msi_pkg::IRQ_IDX_W-1:0] grant_idx
);

  import msi_pkg::*;

  // last line served, search starts one past it
  logic [IRQ_IDX_W-1:0] last_idx;
  // choice captured every unlocked cycle, replayed while locked
  logic [IRQ_IDX_W-1:0] held_idx;
  // combinational search result
  logic [IRQ_IDX_W-1:0] pick_idx;
  logic [IRQ_IDX_W-1:0] cand_idx;
  logic                 pick_found;

  // ---------------------------------------------------------------------
  // round-robin search
  // ---------------------------------------------------------------------
  always_comb begin
    pick_found = 1'b0;
    pick_idx   = last_idx;
    cand_idx   = last_idx;
    // walk all lines, wrapping, lowest distance from the pointer wins
    for (int i = 1; i <= NUM_IRQ; i++) begin
      cand_idx = IRQ_IDX_W'((int'(last_idx) + i) % NUM_IRQ);
      if (!pick_found && pending[cand_idx]) begin
        pick_found = 1'b1;
        pick_idx   = cand_idx;
      end
    end
  end

  // ---------------------------------------------------------------------
  // grant hold
  // ---------------------------------------------------------------------
  // while unlocked the choice follows pending, so a line withdrawn by
  // disable in IDLE/WAIT gets replaced right away
  always_ff @(posedge clk) begin
    if (reset) begin
      held_idx <= '0;
    end else if (!grant_lock) begin
      held_idx <= pick_idx;
    end
  end

  // locked grant stays valid even if its pending bit is masked off,
  // the message is already on the bus
  assign grant_valid = grant_lock | pick_found;
  assign grant_idx   = grant_lock ? held_idx : pick_idx;

  // ---------------------------------------------------------------------
  // pointer update
  // ---------------------------------------------------------------------
  // reset points at the top line so line 0 goes first
  always_ff @(posedge clk) begin
    if (reset) begin
      last_idx <= IRQ_IDX_W'(NUM_IRQ - 1);
    end else if (send_done) begin
      last_idx <= grant_idx;
    end
  end

endmodule

// File: msi_throttle_timer.sv
`timescale 1ns/10ps

module msi_throttle_timer (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           send_done,
  input  logic [msi_pkg::THROTTLE_W-1:0] throttle_threshold,
  output logic                           timer_zero
);

  import msi_pkg::*;

  // cycles left before the next message may start
  logic [THROTTLE_W-1:0] count;

  // ---------------------------------------------------------------------
  // down-counter
  // ---------------------------------------------------------------------
  // reload on every accepted message, then count down and stick at zero
  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (send_done) begin
      count <= throttle_threshold;
    end else if (count != '0) begin
      count <= count - 1'b1;
    end
  end

  // threshold of zero means back to back sends are allowed
  assign timer_zero = (count == '0);

endmodule

// File: msi_msg_builder.sv
`timescale 1ns/10ps

module msi_msg_builder (
  input  logic                                                  clk,
  input  logic                                                  reset,
  input  logic                                                  load_msg,
  input  logic [msi_pkg::IRQ_IDX_W-1:0]                         grant_idx,
  input  logic [msi_pkg::NUM_DEST-1:0][msi_pkg::ADDR_W-1:0]     msi_dest_addr,
  input  logic [msi_pkg::NUM_IRQ-1:0][msi_pkg::DEST_IDX_W-1:0]  msi_dest_idx,
  input  logic [msi_pkg::NUM_IRQ-1:0][msi_pkg::DEVICE_ID_W-1:0] device_id_per_irq,
  input  logic [msi_pkg::NUM_IRQ-1:0][msi_pkg::EVENT_ID_W-1:0]  event_id_per_irq,
  output logic [msi_pkg::ADDR_W-1:0]                            awaddr,
  output logic [msi_pkg::DATA_W-1:0]                            wdata,
  output logic [msi_pkg::STRB_W-1:0]                            wstrb
);

  import msi_pkg::*;

  // granted line's configuration
  logic [DEVICE_ID_W-1:0] dev_id;
  logic [EVENT_ID_W-1:0]  evt_id;
  logic [ADDR_W-1:0]      base_addr;

  // next message fields
  logic [ADDR_W-1:0] addr_next;
  logic [STRB_W-1:0] strb_next;
  msi_wdata_u        data_next;
  msi_wdata_u        data_q;

  assign dev_id    = device_id_per_irq[grant_idx];
  assign evt_id    = event_id_per_irq[grant_idx];
  assign base_addr = msi_dest_addr[msi_dest_idx[grant_idx]];

  // device id is a word offset from the selected base
  assign addr_next = base_addr + {{ADDR_PAD_W{1'b0}}, dev_id, 2'b00};

  always_comb begin
    data_next.word = '0;
    // odd device ids address the upper half of the 64-bit word
    data_next.lane[dev_id[0]] = {{EVENT_PAD_W{1'b0}}, evt_id};
    strb_next = dev_id[0] ? STRB_HI_LANE : STRB_LO_LANE;
  end

  // held until the next load so the bus sees stable payload under stalls
  always_ff @(posedge clk) begin
    if (reset) begin
      awaddr      <= '0;
      data_q.word <= '0;
      wstrb       <= '0;
    end else if (load_msg) begin
      awaddr <= addr_next;
      data_q <= data_next;
      wstrb  <= strb_next;
    end
  end

  assign wdata = data_q.word;

endmodule

// File: msi_send_fsm.sv
`timescale 1ns/10ps

module msi_send_fsm (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       grant_valid,
  input  logic                       throttle_en,
  input  logic                       timer_zero,
  input  logic                       awready,
  input  logic                       wready,
  input  logic                       bvalid,
  input  logic [msi_pkg::RESP_W-1:0] bresp,
  output logic                       load_msg,
  output logic                       grant_lock,
  output logic                       awvalid,
  output logic                       wvalid,
  output logic                       send_done,
  output logic                       error
);

  import msi_pkg::*;

  logic [STATE_W-1:0] state;

  // channel accepted in an earlier cycle of this message
  logic aw_done;
  logic w_done;
  // handshakes this cycle
  logic aw_acc;
  logic w_acc;
  logic clear_to_send;

  // ---------------------------------------------------------------------
  // combinational outputs
  // ---------------------------------------------------------------------
  assign aw_acc = awvalid & awready;
  assign w_acc  = wvalid & wready;

  assign clear_to_send = ~throttle_en | timer_zero;

  // payload is latched as the fsm leaves WAIT
  assign load_msg = (state == ST_WAIT) & grant_valid & clear_to_send;

  // arbiter may only re-choose before the payload is latched
  assign grant_lock = (state == ST_ISSUE);

  // both channels done, either now or earlier
  assign send_done = (state == ST_ISSUE) & (aw_done | aw_acc) & (w_done | w_acc);

  // ---------------------------------------------------------------------
  // state and valids
  // ---------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= ST_IDLE;
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      aw_done <= 1'b0;
      w_done  <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (grant_valid) begin
            state <= ST_WAIT;
          end
        end
        ST_WAIT: begin
          if (load_msg) begin
            state   <= ST_ISSUE;
            awvalid <= 1'b1;
            wvalid  <= 1'b1;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
          end else if (!grant_valid) begin
            // pending line was disabled while waiting on the throttle
            state <= ST_IDLE;
          end
        end
        ST_ISSUE: begin
          // each valid drops on its own ready
          if (aw_acc) begin
            awvalid <= 1'b0;
            aw_done <= 1'b1;
          end
          if (w_acc) begin
            wvalid <= 1'b0;
            w_done <= 1'b1;
          end
          if (send_done) begin
            state   <= ST_IDLE;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // ---------------------------------------------------------------------
  // response
  // ---------------------------------------------------------------------
  // bready is tied high at the interface, every bvalid is a response
  always_ff @(posedge clk) begin
    if (reset) begin
      error <= 1'b0;
    end else if (bvalid) begin
      error <= (bresp != RESP_OKAY);
    end
  end

endmodule

// File: msi_axil_gen.sv
`timescale 1ns/10ps

module msi_axil_gen (
  input  logic                                                  clk,
  input  logic                                                  reset,
  // interrupt lines
  input  logic [msi_pkg::NUM_IRQ-1:0]                           irq,
  // message configuration
  input  logic [msi_pkg::NUM_DEST-1:0][msi_pkg::ADDR_W-1:0]     msi_dest_addr,
  input  logic [msi_pkg::NUM_IRQ-1:0]                           msi_enable,
  input  logic [msi_pkg::NUM_IRQ-1:0][msi_pkg::DEST_IDX_W-1:0]  msi_dest_idx,
  input  logic [msi_pkg::NUM_IRQ-1:0][msi_pkg::DEVICE_ID_W-1:0] device_id_per_irq,
  input  logic [msi_pkg::NUM_IRQ-1:0][msi_pkg::EVENT_ID_W-1:0]  event_id_per_irq,
  // throttle configuration
  input  logic                                                  throttle_en,
  input  logic [msi_pkg::THROTTLE_W-1:0]                        throttle_threshold,
  // last response was not OKAY
  output logic                                                  error,
  // AXI4-Lite write-only initiator, bready is implied high
  output logic [msi_pkg::ADDR_W-1:0]                            awaddr,
  output logic                                                  awvalid,
  input  logic                                                  awready,
  output logic [msi_pkg::DATA_W-1:0]                            wdata,
  output logic [msi_pkg::STRB_W-1:0]                            wstrb,
  output logic                                                  wvalid,
  input  logic                                                  wready,
  input  logic [msi_pkg::RESP_W-1:0]                            bresp,
  input  logic                                                  bvalid
);

  import msi_pkg::*;

  logic [NUM_IRQ-1:0]   pending;
  logic                 grant_valid;
  logic [IRQ_IDX_W-1:0] grant_idx;
  logic                 grant_lock;
  logic                 send_done;
  logic                 load_msg;
  logic                 timer_zero;

  // ---------------------------------------------------------------------
  // capture and arbitration
  // ---------------------------------------------------------------------
  msi_irq_tracker u_msi_irq_tracker (
    .clk        (clk),
    .reset      (reset),
    .irq        (irq),
    .msi_enable (msi_enable),
    .grant_idx  (grant_idx),
    .send_done  (send_done),
    .pending    (pending)
  );

  msi_rr_arbiter u_msi_rr_arbiter (
    .clk         (clk),
    .reset       (reset),
    .pending     (pending),
    .send_done   (send_done),
    .grant_lock  (grant_lock),
    .grant_valid (grant_valid),
    .grant_idx   (grant_idx)
  );

  // ---------------------------------------------------------------------
  // spacing, payload and bus sequencing
  // ---------------------------------------------------------------------
  msi_throttle_timer u_msi_throttle_timer (
    .clk                (clk),
    .reset              (reset),
    .send_done          (send_done),
    .throttle_threshold (throttle_threshold),
    .timer_zero         (timer_zero)
  );

  msi_msg_builder u_msi_msg_builder (
    .clk               (clk),
    .reset             (reset),
    .load_msg          (load_msg),
    .grant_idx         (grant_idx),
    .msi_dest_addr     (msi_dest_addr),
    .msi_dest_idx      (msi_dest_idx),
    .device_id_per_irq (device_id_per_irq),
    .event_id_per_irq  (event_id_per_irq),
    .awaddr            (awaddr),
    .wdata             (wdata),
    .wstrb             (wstrb)
  );

  msi_send_fsm u_msi_send_fsm (
    .clk         (clk),
    .reset       (reset),
    .grant_valid (grant_valid),
    .throttle_en (throttle_en),
    .timer_zero  (timer_zero),
    .awready     (awready),
    .wready      (wready),
    .bvalid      (bvalid),
    .bresp       (bresp),
    .load_msg    (load_msg),
    .grant_lock  (grant_lock),
    .awvalid     (awvalid),
    .wvalid      (wvalid),
    .send_done   (send_done),
    .error       (error)
  );

endmodule

// File: tb_msi_axil_gen.sv
`timescale 1ns/10ps

module tb_msi_axil_gen;

  import msi_pkg::*;

  // per-test cycle budgets, summed for the watchdog
  localparam int RESET_CYC   = 8;
  localparam int BUDGET_CYC  = 80 + 120 + 100 + 220 + 320 + 80;
  localparam int WATCHDOG_NS = (RESET_CYC + BUDGET_CYC + 100) * 40;
  localparam int THR_T       = 12;

  logic clk = 1'b0;
  logic reset;
  logic [NUM_IRQ-1:0]                  irq;
  logic [NUM_DEST-1:0][ADDR_W-1:0]     msi_dest_addr;
  logic [NUM_IRQ-1:0]                  msi_enable;
  logic [NUM_IRQ-1:0][DEST_IDX_W-1:0]  msi_dest_idx;
  logic [NUM_IRQ-1:0][DEVICE_ID_W-1:0] device_id_per_irq;
  logic [NUM_IRQ-1:0][EVENT_ID_W-1:0]  event_id_per_irq;
  logic                                throttle_en;
  logic [THROTTLE_W-1:0]               throttle_threshold;
  logic                                error;
  logic [ADDR_W-1:0]                   awaddr;
  logic                                awvalid;
  logic                                awready;
  logic [DATA_W-1:0]                   wdata;
  logic [STRB_W-1:0]                   wstrb;
  logic                                wvalid;
  logic                                wready;
  logic [RESP_W-1:0]                   bresp;
  logic                                bvalid;

  // responder controls
  logic              stall_en  = 1'b0;
  logic [RESP_W-1:0] bresp_cfg = RESP_OKAY;
  logic              resp_due  = 1'b0;
  integer            seed      = 72476;

  // write log filled by the monitor
  logic [ADDR_W-1:0] got_addr[$];
  logic [DATA_W-1:0] got_data[$];
  logic [STRB_W-1:0] got_strb[$];
  int                rise_cyc[$];
  int                done_cyc[$];
  logic              aw_seen = 1'b0;
  logic              w_seen  = 1'b0;
  logic [ADDR_W-1:0] addr_hold;
  logic [DATA_W-1:0] data_hold;
  logic [STRB_W-1:0] strb_hold;
  logic              awvalid_q = 1'b0;
  int                cyc = 0;

  // bookkeeping
  int last_line    = NUM_IRQ - 1;
  int test_fails   = 0;
  int fails        = 0;
  int tests_run    = 0;
  int tests_failed = 0;

  msi_axil_gen u_msi_axil_gen (
    .clk                (clk),
    .reset              (reset),
    .irq                (irq),
    .msi_dest_addr      (msi_dest_addr),
    .msi_enable         (msi_enable),
    .msi_dest_idx       (msi_dest_idx),
    .device_id_per_irq  (device_id_per_irq),
    .event_id_per_irq   (event_id_per_irq),
    .throttle_en        (throttle_en),
    .throttle_threshold (throttle_threshold),
    .error              (error),
    .awaddr             (awaddr),
    .awvalid            (awvalid),
    .awready            (awready),
    .wdata              (wdata),
    .wstrb              (wstrb),
    .wvalid             (wvalid),
    .wready             (wready),
    .bresp              (bresp),
    .bvalid             (bvalid)
  );

  // ----------------------------------------------------------------------
  // clock, cycle count, AXI responder and monitor
  // ----------------------------------------------------------------------
  always #20 clk = ~clk;

  always @(posedge clk) cyc <= cyc + 1;

  // readies and response change 2 ns after the edge
  initial begin
    awready = 1'b0;
    wready  = 1'b0;
    bvalid  = 1'b0;
    bresp   = RESP_OKAY;
    forever begin
      @(posedge clk);
      #2;
      // one-cycle response right after both channels completed
      bvalid   = resp_due;
      bresp    = resp_due ? bresp_cfg : RESP_OKAY;
      resp_due = 1'b0;
      if (stall_en) begin
        awready = (($random(seed) & 3) != 0);
        wready  = (($random(seed) & 3) != 0);
      end else begin
        awready = 1'b1;
        wready  = 1'b1;
      end
    end
  end

  // negedge sees what the next rising edge will accept
  always @(negedge clk) begin
    if (!reset) begin
      if (awvalid && !awvalid_q) rise_cyc.push_back(cyc);
      if (awvalid && awready) begin
        aw_seen   = 1'b1;
        addr_hold = awaddr;
      end
      if (wvalid && wready) begin
        w_seen    = 1'b1;
        data_hold = wdata;
        strb_hold = wstrb;
      end
      // both halves in, write completes on the coming edge
      if (aw_seen && w_seen) begin
        got_addr.push_back(addr_hold);
        got_data.push_back(data_hold);
        got_strb.push_back(strb_hold);
        done_cyc.push_back(cyc + 1);
        aw_seen  = 1'b0;
        w_seen   = 1'b0;
        resp_due = 1'b1;
        $display("write addr %h data %h strb %h at %0t", addr_hold, data_hold, strb_hold,
                 $time);
      end
    end
    awvalid_q = awvalid;
  end

  // ----------------------------------------------------------------------
  // helpers
  // ----------------------------------------------------------------------
  task automatic tick(input int n);
    repeat (n) @(posedge clk);
    #2;
  endtask

  task automatic check(input string name, input logic [63:0] expected,
                       input logic [63:0] actual);
    if (expected !== actual) begin
      $display("error at %0t: %s expected %h got %h", $time, name, expected, actual);
      test_fails++;
    end
  endtask

  task automatic clear_log();
    got_addr.delete();
    got_data.delete();
    got_strb.delete();
    rise_cyc.delete();
    done_cyc.delete();
  endtask

  task automatic start_test();
    test_fails = 0;
    clear_log();
  endtask

  task automatic end_test(input string name);
    tests_run++;
    fails += test_fails;
    if (test_fails == 0) begin
      $display("test %s: pass", name);
    end else begin
      tests_failed++;
      $display("test %s: fail with %0d mismatches", name, test_fails);
    end
  endtask

  task automatic pulse_irq(input logic [NUM_IRQ-1:0] mask);
    irq = irq | mask;
    tick(1);
    irq = irq & ~mask;
  endtask

  // block until n writes are logged or the cycle limit runs out
  task automatic wait_writes(input int n, input int max_cycles);
    int waited;
    waited = 0;
    while (got_addr.size() < n && waited < max_cycles) begin
      tick(1);
      waited++;
    end
    if (got_addr.size() < n) begin
      $display("only %0d of %0d expected writes arrived within %0d cycles",
               got_addr.size(), n, max_cycles);
      test_fails++;
    end
  endtask

  // expected write for a line, from the address, lane and strobe rules
  task automatic check_write(input int k, input int line);
    msi_wdata_u             exp_data;
    logic [ADDR_W-1:0]      exp_addr;
    logic [STRB_W-1:0]      exp_strb;
    logic [DEVICE_ID_W-1:0] dev;
    dev      = device_id_per_irq[line];
    exp_addr = msi_dest_addr[msi_dest_idx[line]] + (ADDR_W'(dev) << 2);
    exp_data.word = '0;
    exp_data.lane[dev[0]] = LANE_W'(event_id_per_irq[line]);
    exp_strb = dev[0] ? STRB_HI_LANE : STRB_LO_LANE;
    last_line = line;
    if (k < got_addr.size()) begin
      check($sformatf("awaddr[%0d]", k), exp_addr, got_addr[k]);
      check($sformatf("wdata[%0d]", k), exp_data.word, got_data[k]);
      check($sformatf("wstrb[%0d]", k), exp_strb, got_strb[k]);
    end
  endtask

  // all lines pending at once, served in order after the last one
  task automatic check_burst();
    for (int k = 0; k < NUM_IRQ; k++) begin
      check_write(k, (last_line + 1) % NUM_IRQ);
    end
  endtask

  // ----------------------------------------------------------------------
  // tests
  // ----------------------------------------------------------------------
  task automatic test_single_write();
    start_test();
    check("awvalid", 0, awvalid);
    check("wvalid", 0, wvalid);
    irq[0] = 1'b1;
    wait_writes(1, 40);
    check_write(0, 0);
    // line stays high, no second message
    tick(40);
    check("write_count", 1, got_addr.size());
    irq[0] = 1'b0;
    tick(2);
    end_test("single_write");
  endtask

  task automatic test_odd_dest1();
    start_test();
    pulse_irq(4'b0010);
    wait_writes(1, 40);
    check_write(0, 1);
    tick(4);
    pulse_irq(4'b0010);
    wait_writes(2, 40);
    check_write(1, 1);
    check("write_count", 2, got_addr.size());
    end_test("odd_dest1");
  endtask

  task automatic test_enable_mask();
    start_test();
    msi_enable[2] = 1'b0;
    pulse_irq(4'b0100);
    tick(40);
    check("write_count", 0, got_addr.size());
    // enabling later must not bring back the dropped edge
    msi_enable[2] = 1'b1;
    tick(40);
    check("write_count", 0, got_addr.size());
    end_test("enable_mask");
  endtask

  task automatic test_round_robin();
    start_test();
    stall_en = 1'b1;
    pulse_irq(4'b1111);
    wait_writes(4, 200);
    stall_en = 1'b0;
    tick(4);
    check("write_count", 4, got_addr.size());
    check_burst();
    end_test("round_robin");
  endtask

  task automatic test_throttle();
    int gap;
    start_test();
    throttle_en        = 1'b1;
    throttle_threshold = THROTTLE_W'(THR_T);
    pulse_irq(4'b1111);
    wait_writes(4, 200);
    tick(4);
    check_burst();
    for (int k = 1; k < NUM_IRQ; k++) begin
      if (k < rise_cyc.size() && k - 1 < done_cyc.size()) begin
        gap = rise_cyc[k] - done_cyc[k-1];
        check($sformatf("gap_at_least_%0d[%0d]", THR_T, k), 1, gap >= THR_T);
      end
    end
    // same burst with throttling off
    throttle_en = 1'b0;
    clear_log();
    pulse_irq(4'b1111);
    wait_writes(4, 100);
    tick(4);
    check_burst();
    end_test("throttle");
  endtask

  task automatic test_error_level();
    int waited;
    start_test();
    check("error", 0, error);
    bresp_cfg = 2'b10;
    pulse_irq(4'b0001);
    wait_writes(1, 40);
    waited = 0;
    while (error !== 1'b1 && waited < 10) begin
      tick(1);
      waited++;
    end
    check("error", 1, error);
    bresp_cfg = RESP_OKAY;
    pulse_irq(4'b0001);
    wait_writes(2, 40);
    waited = 0;
    while (error !== 1'b0 && waited < 10) begin
      tick(1);
      waited++;
    end
    check("error", 0, error);
    end_test("error_level");
  endtask

  // ----------------------------------------------------------------------
  // main sequence and watchdog
  // ----------------------------------------------------------------------
  initial begin
    reset              = 1'b1;
    irq                = '0;
    msi_enable         = '1;
    throttle_en        = 1'b0;
    throttle_threshold = '0;
    msi_dest_addr[0]   = 40'h00_1000_0000;
    msi_dest_addr[1]   = 40'h80_2000_0000;
    // even and odd device ids spread over both bases
    device_id_per_irq[0] = 16'h0010;
    device_id_per_irq[1] = 16'h0023;
    device_id_per_irq[2] = 16'h0104;
    device_id_per_irq[3] = 16'h0ff1;
    msi_dest_idx[0] = 1'b0;
    msi_dest_idx[1] = 1'b1;
    msi_dest_idx[2] = 1'b1;
    msi_dest_idx[3] = 1'b0;
    event_id_per_irq[0] = 16'ha5a0;
    event_id_per_irq[1] = 16'h5a51;
    event_id_per_irq[2] = 16'hc3c2;
    event_id_per_irq[3] = 16'h3c33;
    repeat (RESET_CYC) @(posedge clk);
    #2;
    reset = 1'b0;
    tick(2);
    test_single_write();
    test_odd_dest1();
    test_enable_mask();
    test_round_robin();
    test_throttle();
    test_error_level();
    $display("tests run %0d, tests failed %0d, mismatches %0d", tests_run, tests_failed,
             fails);
    if (fails == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
    $display("Test failures found");
    $finish;
  end

endmodule

// File: build.f
msi_pkg.sv
msi_irq_tracker.sv
msi_rr_arbiter.sv
msi_throttle_timer.sv
msi_msg_builder.sv
msi_send_fsm.sv
msi_axil_gen.sv
tb_msi_axil_gen.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f build.f --top-module tb_msi_axil_gen \
  -o tb_msi_axil_gen > build.log 2>&1 || { cat build.log; echo "compile failed"; exit 1; }

./obj_dir/tb_msi_axil_gen > sim.log 2>&1
cat sim.log

grep -q "Test failures found" sim.log && echo "simulation failed" && exit 1
grep -q "All tests passed!" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
exit 0
